//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_mem_subsystem
BUILD_DIR ?= obj_dir
FILELIST ?= all.f
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+common
common/mem_req_pkg.sv
common/icache_pkg.sv
hw/req_queue.sv
memctrl/mem_ctrl.sv
icache/icache.sv
hw/mem_subsystem.sv
bench/ram_model.sv
bench/tb_mem_subsystem.sv

//--- bench/mem_cases.txt
# P addr byte | S addr data len pause | L addr len sext tag expected pause
# F addr expected hit_now | I io_full io_byte | B count, then count L lines
S 100 8765a3c1 3 0
L 100 3 0 1 8765a3c1 0
S 108 0000f00d 1 0
L 108 1 1 2 fffff00d 0
S 10c 00000085 0 0
L 10c 0 0 3 00000085 0
L 10c 0 1 4 ffffff85 0
S 200 11223344 3 3
L 200 3 0 5 11223344 4
P 40 93
P 41 00
P 42 a0
P 43 00
P 44 13
P 45 81
P 46 10
P 47 00
F 44 00108113 0
F 40 00a00093 1
B 5
L 100 3 0 6 8765a3c1 0
L 102 1 1 7 ffff8765 0
L 108 0 0 8 0000000d 0
L 109 0 1 9 fffffff0 0
L 10c 1 0 a 00000085 0
I 1 0
S 30000 00000041 0 0
L 200 3 0 b 11223344 0
I 0 41

//--- bench/ram_model.sv
// byte ram model
`timescale 1ns/1ps

module ram_model (
    input  logic        clk_in,
    input  logic        rdy_in,
    input  logic [31:0] mem_a,
    input  logic [7:0]  mem_dout,
    input  logic        mem_wr,
    output logic [7:0]  mem_din
);
    logic [7:0]  mem [131072];
    int          io_count;
    logic [7:0]  io_last;

    initial begin
        io_count = 0;
        io_last = 8'h00;
        mem_din = 8'h00;
        // fill depends on every address bit
        for (int i = 0; i < 131072; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ {7'b0, i[16]};
        end
    end

    task automatic preload(input logic [31:0] addr, input logic [7:0] value);
        mem[addr[16:0]] = value;
    endtask

    always @(posedge clk_in) begin
        if (rdy_in) begin
            mem_din <= mem[mem_a[16:0]];
            if (mem_wr) begin
                if (mem_a[17:16] == 2'b11) begin
                    io_count <= io_count + 1;
                    io_last <= mem_dout;
                end else begin
                    mem[mem_a[16:0]] <= mem_dout;
                end
            end
        end
    end

endmodule

//--- bench/tb_mem_subsystem.sv
// memory subsystem testbench
`timescale 1ns/1ps

module tb_mem_subsystem
    import mem_req_pkg::*;
;
    logic        clk_in;
    logic        rst_in;
    logic        rdy_in;
    logic [31:0] fetch_addr;
    logic        fetch_hit;
    logic [31:0] fetch_inst;
    logic        ld_valid;
    logic [31:0] ld_addr;
    access_len_t ld_len;
    logic        ld_sext;
    logic [3:0]  ld_tag_in;
    logic        ld_full;
    logic        ld_done;
    logic [31:0] ld_data;
    logic [3:0]  ld_tag;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    access_len_t st_len;
    logic        st_full;
    logic        st_done;
    logic        io_full;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;

    logic [31:0] got_data [$];
    logic [3:0]  got_tag [$];
    int          st_count;
    int          st_issued;
    int          seed;

    mem_subsystem mem_subsystem_i (
        .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
        .fetch_addr(fetch_addr), .fetch_hit(fetch_hit), .fetch_inst(fetch_inst),
        .ld_valid(ld_valid), .ld_addr(ld_addr), .ld_len(ld_len), .ld_sext(ld_sext),
        .ld_tag_in(ld_tag_in), .ld_full(ld_full), .ld_done(ld_done),
        .ld_data(ld_data), .ld_tag(ld_tag),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data), .st_len(st_len),
        .st_full(st_full), .st_done(st_done), .io_buffer_full(io_full),
        .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
    );

    ram_model ram_i (
        .clk_in(clk_in), .rdy_in(rdy_in), .mem_a(mem_a),
        .mem_dout(mem_dout), .mem_wr(mem_wr), .mem_din(mem_din)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        end
    endtask

    // completions are taken on edges where the DUT is not paused
    always @(posedge clk_in) begin
        if (!rst_in) begin
            if (!rdy_in && mem_wr) begin
                fail_run("mem_wr went high while rdy_in was low");
            end
            if (mem_wr && io_full && mem_a[17:16] == 2'b11) begin
                fail_run("an i/o write happened while the i/o buffer was full");
            end
            if (rdy_in && ld_done) begin
                got_data.push_back(ld_data);
                got_tag.push_back(ld_tag);
            end
            if (rdy_in && st_done) begin
                st_count++;
            end
        end
    end

    task automatic pause_cycles(input int n);
        if (n > 0) begin
            repeat (2) @(negedge clk_in);
            rdy_in = 1'b0;
            repeat (n) begin
                @(negedge clk_in);
                // a frozen access cannot complete
                check_value("ld_done", {31'b0, ld_done}, 32'h0);
                check_value("st_done", {31'b0, st_done}, 32'h0);
            end
            rdy_in = 1'b1;
        end
    endtask

    task automatic wait_stores_done();
        int t;
        t = 0;
        while (st_count != st_issued) begin
            @(negedge clk_in);
            t++;
            if (t > 300) fail_run("timed out waiting for st_done");
        end
    endtask

    task automatic check_next_load(input logic [3:0] tag, input logic [31:0] exp);
        int t;
        t = 0;
        while (got_data.size() == 0) begin
            @(negedge clk_in);
            t++;
            if (t > 300) fail_run("timed out waiting for ld_done");
        end
        check_value("ld_data", got_data.pop_front(), exp);
        check_value("ld_tag", {28'b0, got_tag.pop_front()}, {28'b0, tag});
    endtask

    task automatic do_store(input logic [31:0] a, input logic [31:0] d,
                            input logic [1:0] len, input int pause);
        int t;
        t = 0;
        while (st_full) begin
            @(negedge clk_in);
            t++;
            if (t > 300) fail_run("store queue stayed full");
        end
        st_valid = 1'b1;
        st_addr = a;
        st_data = d;
        st_len = access_len_t'(len);
        @(negedge clk_in);
        st_valid = 1'b0;
        st_issued++;
        pause_cycles(pause);
        if (!io_full) wait_stores_done();
    endtask

    task automatic drive_load(input logic [31:0] a, input logic [1:0] len,
                              input logic sext, input logic [3:0] tag);
        ld_valid = 1'b1;
        ld_addr = a;
        ld_len = access_len_t'(len);
        ld_sext = sext;
        ld_tag_in = tag;
    endtask

    task automatic do_load(input logic [31:0] a, input logic [1:0] len, input logic sext,
                           input logic [3:0] tag, input logic [31:0] exp, input int pause);
        int t;
        t = 0;
        while (ld_full) begin
            @(negedge clk_in);
            t++;
            if (t > 300) fail_run("load queue stayed full");
        end
        drive_load(a, len, sext, tag);
        @(negedge clk_in);
        ld_valid = 1'b0;
        pause_cycles(pause);
        check_next_load(tag, exp);
    endtask

    task automatic do_fetch(input logic [31:0] a, input logic [31:0] exp, input logic hit_now);
        int t;
        t = 0;
        fetch_addr = a;
        #1;
        check_value("fetch_hit", {31'b0, fetch_hit}, {31'b0, hit_now});
        while (!fetch_hit) begin
            @(negedge clk_in);
            t++;
            if (t > 300) fail_run("timed out waiting for fetch_hit");
        end
        check_value("fetch_inst", fetch_inst, exp);
    endtask

    initial begin
        int fd;
        int n;
        int gap;
        int pause;
        logic [7:0] op;
        logic [31:0] f1, f2, f3, f4, f5, f6;
        logic [8*256-1:0] skip;
        logic [3:0] exp_tag [$];
        logic [31:0] exp_data [$];
        logic full_seen;

        seed = 32'h3295dcb7;
        rst_in = 1'b1;
        rdy_in = 1'b1;
        fetch_addr = 32'h0;
        ld_valid = 1'b0;
        ld_addr = 32'h0;
        ld_len = LEN_BYTE;
        ld_sext = 1'b0;
        ld_tag_in = 4'h0;
        st_valid = 1'b0;
        st_addr = 32'h0;
        st_data = 32'h0;
        st_len = LEN_BYTE;
        io_full = 1'b0;
        st_count = 0;
        st_issued = 0;
        repeat (3) @(negedge clk_in);
        rst_in = 1'b0;

        // quiet outputs right after reset
        repeat (4) begin
            @(negedge clk_in);
            check_value("ld_done", {31'b0, ld_done}, 32'h0);
            check_value("st_done", {31'b0, st_done}, 32'h0);
            check_value("mem_wr", {31'b0, mem_wr}, 32'h0);
            check_value("ld_full", {31'b0, ld_full}, 32'h0);
            check_value("st_full", {31'b0, st_full}, 32'h0);
            check_value("fetch_hit", {31'b0, fetch_hit}, 32'h0);
        end

        fd = $fopen("bench/mem_cases.txt", "r");
        if (fd == 0) fail_run("could not open the cases file");
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": n = $fgets(skip, fd);
                "P": begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    ram_i.preload(f1, f2[7:0]);
                end
                "S": begin
                    n = $fscanf(fd, "%h %h %h %d", f1, f2, f3, pause);
                    do_store(f1, f2, f3[1:0], pause);
                end
                "L": begin
                    n = $fscanf(fd, "%h %h %h %h %h %d", f1, f2, f3, f4, f5, pause);
                    do_load(f1, f2[1:0], f3[0], f4[3:0], f5, pause);
                end
                "F": begin
                    n = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    do_fetch(f1, f2, f3[0]);
                end
                "I": begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    f6 = ram_i.io_count;
                    io_full = f1[0];
                    if (!io_full) begin
                        wait_stores_done();
                        @(negedge clk_in);
                        check_value("io_count", ram_i.io_count, f6 + 32'd1);
                        check_value("io_byte", {24'b0, ram_i.io_last}, f2);
                    end
                end
                "B": begin
                    n = $fscanf(fd, "%d", gap);
                    full_seen = 1'b0;
                    repeat (gap) begin
                        n = $fscanf(fd, " %c %h %h %h %h %h %d",
                                    op, f1, f2, f3, f4, f5, pause);
                        drive_load(f1, f2[1:0], f3[0], f4[3:0]);
                        if (ld_full) begin
                            full_seen = 1'b1;
                        end else begin
                            exp_tag.push_back(f4[3:0]);
                            exp_data.push_back(f5);
                        end
                        @(negedge clk_in);
                    end
                    ld_valid = 1'b0;
                    check_value("ld_full_seen", {31'b0, full_seen}, 32'h1);
                    while (exp_data.size() > 0) begin
                        check_next_load(exp_tag.pop_front(), exp_data.pop_front());
                    end
                end
                default: fail_run("unknown operation in the cases file");
            endcase
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk_in);
        end
        $fclose(fd);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- common/icache_pkg.sv
// instruction cache types
`include "mem_settings.svh"

package icache_pkg;

    localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
    localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
    // tag covers the rest of the decoded address
    localparam int TAG_BITS = `RAM_ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    typedef logic [`LINE_BYTES*8-1:0] line_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0] cache_tag_t;

endpackage

//--- common/mem_req_pkg.sv
// load and store request types
package mem_req_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // chosen by the requester, returned with the load data
    typedef logic [3:0] tag_t;

    // value is the index of the last byte of the access
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd3
    } access_len_t;

    typedef struct packed {
        addr_t       addr;
        access_len_t len;
        logic        sext;
        tag_t        tag;
    } load_req_t;

    typedef struct packed {
        addr_t       addr;
        word_t       data;
        access_len_t len;
    } store_req_t;

endpackage

//--- common/mem_settings.svh
// memory subsystem geometry
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ram address bits actually decoded
`define RAM_ADDR_BITS 18

// instruction cache shape
`define LINE_BYTES 8
`define ICACHE_LINES 16

// entries in each request queue
`define REQ_QUEUE_DEPTH 2

// addr[17:16] value of the i/o window
`define IO_REGION 2'b11

`endif

//--- hw/mem_subsystem.sv
// memory subsystem top
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem
    import mem_req_pkg::*;
    import icache_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        rdy_in,
    input  addr_t       fetch_addr,
    output logic        fetch_hit,
    output word_t       fetch_inst,
    input  logic        ld_valid,
    input  addr_t       ld_addr,
    input  access_len_t ld_len,
    input  logic        ld_sext,
    input  tag_t        ld_tag_in,
    output logic        ld_full,
    output logic        ld_done,
    output word_t       ld_data,
    output tag_t        ld_tag,
    input  logic        st_valid,
    input  addr_t       st_addr,
    input  word_t       st_data,
    input  access_len_t st_len,
    output logic        st_full,
    output logic        st_done,
    input  logic        io_buffer_full,
    input  logic [7:0]  mem_din,
    output logic [7:0]  mem_dout,
    output addr_t       mem_a,
    output logic        mem_wr
);
    load_req_t  ld_req;
    load_req_t  ld_head;
    store_req_t st_req;
    store_req_t st_head;
    logic       ld_pending;
    logic       ld_pop;
    logic       st_pending;
    logic       st_pop;
    logic       fill_req;
    logic       fill_done;
    addr_t      fill_addr;
    line_t      fill_line;

    assign ld_req = '{addr: ld_addr, len: ld_len, sext: ld_sext, tag: ld_tag_in};
    assign st_req = '{addr: st_addr, data: st_data, len: st_len};

    // a request made while full is dropped
    req_queue #(.payload_t(load_req_t)) load_queue (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .rdy_in(rdy_in),
        .push(ld_valid && !ld_full),
        .push_data(ld_req),
        .full(ld_full),
        .pop(ld_pop),
        .head(ld_head),
        .not_empty(ld_pending)
    );

    req_queue #(.payload_t(store_req_t)) store_queue (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .rdy_in(rdy_in),
        .push(st_valid && !st_full),
        .push_data(st_req),
        .full(st_full),
        .pop(st_pop),
        .head(st_head),
        .not_empty(st_pending)
    );

    icache icache_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .rdy_in(rdy_in),
        .fetch_addr(fetch_addr),
        .fetch_hit(fetch_hit),
        .fetch_inst(fetch_inst),
        .fill_req(fill_req),
        .fill_addr(fill_addr),
        .fill_done(fill_done),
        .fill_line(fill_line)
    );

    mem_ctrl mem_ctrl_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .rdy_in(rdy_in),
        .io_buffer_full(io_buffer_full),
        .st_head(st_head),
        .st_pending(st_pending),
        .st_pop(st_pop),
        .ld_head(ld_head),
        .ld_pending(ld_pending),
        .ld_pop(ld_pop),
        .fill_req(fill_req),
        .fill_addr(fill_addr),
        .fill_done(fill_done),
        .fill_line(fill_line),
        .ld_done(ld_done),
        .ld_data(ld_data),
        .ld_tag(ld_tag),
        .st_done(st_done),
        .mem_din(mem_din),
        .mem_dout(mem_dout),
        .mem_a(mem_a),
        .mem_wr(mem_wr)
    );

endmodule

//--- hw/req_queue.sv
// pending request fifo
`timescale 1ns/1ps
`include "mem_settings.svh"

module req_queue
    import mem_req_pkg::*;
#(
    parameter type payload_t = load_req_t,
    parameter int  DEPTH = `REQ_QUEUE_DEPTH
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t            entries [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS:0]   count;

    function automatic logic [PTR_BITS-1:0] next_ptr(logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == (PTR_BITS + 1)'(DEPTH));
    assign not_empty = (count != '0);
    assign head = entries[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (rdy_in) begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    // requester side must respect full, controller side must respect not_empty
    a_no_overflow: assert property (@(posedge clk_in) disable iff (rst_in)
        rdy_in && push |-> !full);
    a_no_underflow: assert property (@(posedge clk_in) disable iff (rst_in)
        rdy_in && pop |-> not_empty);

endmodule

//--- icache/icache.sv
// direct-mapped instruction cache
`timescale 1ns/1ps
`include "mem_settings.svh"

module icache
    import mem_req_pkg::*;
    import icache_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  rdy_in,
    input  addr_t fetch_addr,
    output logic  fetch_hit,
    output word_t fetch_inst,
    output logic  fill_req,
    output addr_t fill_addr,
    input  logic  fill_done,
    input  line_t fill_line
);
    logic [`ICACHE_LINES-1:0] valid_q;
    cache_tag_t               tag_arr [`ICACHE_LINES];
    line_t                    line_arr [`ICACHE_LINES];
    index_t                   fetch_idx;
    index_t                   fill_idx;
    cache_tag_t               fetch_tag;
    logic [OFFSET_BITS-3:0]   word_sel;
    logic                     pend_q;
    addr_t                    pend_addr_q;
    logic                     start_fill;

    assign fetch_idx = fetch_addr[OFFSET_BITS +: INDEX_BITS];
    assign fetch_tag = fetch_addr[`RAM_ADDR_BITS-1 -: TAG_BITS];
    assign word_sel = fetch_addr[OFFSET_BITS-1:2];
    assign fill_idx = pend_addr_q[OFFSET_BITS +: INDEX_BITS];

    assign fetch_hit = valid_q[fetch_idx] && (tag_arr[fetch_idx] == fetch_tag);
    assign fetch_inst = line_arr[fetch_idx][word_sel*32 +: 32];

    // one fill in flight, the line address is latched at the miss
    assign start_fill = !pend_q && !fetch_hit;
    assign fill_req = pend_q;
    assign fill_addr = pend_addr_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_q <= '0;
            pend_q <= 1'b0;
        end else if (rdy_in) begin
            if (pend_q && fill_done) begin
                valid_q[fill_idx] <= 1'b1;
                pend_q <= 1'b0;
            end else if (start_fill) begin
                pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (start_fill) begin
                pend_addr_q <= {fetch_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end
            if (pend_q && fill_done) begin
                tag_arr[fill_idx] <= pend_addr_q[`RAM_ADDR_BITS-1 -: TAG_BITS];
                line_arr[fill_idx] <= fill_line;
            end
        end
    end

    // controller only answers a fill that is still requested
    a_fill_pending: assert property (@(posedge clk_in) disable iff (rst_in)
        fill_done |-> fill_req);

endmodule

//--- memctrl/mem_ctrl.sv
// memory controller
// request arbitration and byte-serial ram access
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_ctrl
    import mem_req_pkg::*;
    import icache_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       rdy_in,
    input  logic       io_buffer_full,
    input  store_req_t st_head,
    input  logic       st_pending,
    output logic       st_pop,
    input  load_req_t  ld_head,
    input  logic       ld_pending,
    output logic       ld_pop,
    input  logic       fill_req,
    input  addr_t      fill_addr,
    output logic       fill_done,
    output line_t      fill_line,
    output logic       ld_done,
    output word_t      ld_data,
    output tag_t       ld_tag,
    output logic       st_done,
    input  logic [7:0] mem_din,
    output logic [7:0] mem_dout,
    output addr_t      mem_a,
    output logic       mem_wr
);
    localparam int CNT_BITS = $clog2(`LINE_BYTES) + 1;

    typedef enum logic [1:0] {IDLE, READ, WRITE} state_t;

    state_t                 state;
    logic [CNT_BITS-1:0]    cnt;
    logic [CNT_BITS-1:0]    last_q;
    logic                   fill_q;
    logic                   mem_wr_q;
    logic [23:0]            wdata_q;
    line_t                  asm_q;
    access_len_t            len_q;
    logic                   sext_q;
    logic                   st_blocked;
    logic                   st_go;
    logic                   ld_go;
    logic                   fill_go;
    logic [OFFSET_BITS-1:0] rx_idx;

    function automatic word_t extend(word_t raw, access_len_t len, logic sext);
        case (len)
            LEN_BYTE: return {{24{sext & raw[7]}}, raw[7:0]};
            LEN_HALF: return {{16{sext & raw[15]}}, raw[15:0]};
            default:  return raw;
        endcase
    endfunction

    // i/o stores wait while the uart buffer is full
    assign st_blocked = (st_head.addr[`RAM_ADDR_BITS-1 -: 2] == `IO_REGION) && io_buffer_full;

    // fixed priority: store, load, line fill
    assign st_go = (state == IDLE) && st_pending && !st_blocked;
    assign ld_go = (state == IDLE) && !st_go && ld_pending;
    // fill_req is still high in the fill_done cycle
    assign fill_go = (state == IDLE) && !st_go && !ld_pending && fill_req && !fill_done;

    assign st_pop = st_go && rdy_in;
    assign ld_pop = ld_go && rdy_in;

    // byte addressed in the previous cycle
    assign rx_idx = cnt[OFFSET_BITS-1:0] - 1'b1;

    assign mem_wr = mem_wr_q && rdy_in;
    assign fill_line = asm_q;
    assign ld_data = extend(asm_q[31:0], len_q, sext_q);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
            cnt <= '0;
            mem_wr_q <= 1'b0;
            ld_done <= 1'b0;
            st_done <= 1'b0;
            fill_done <= 1'b0;
            mem_a <= '0;
            mem_dout <= '0;
        end else if (rdy_in) begin
            ld_done <= 1'b0;
            st_done <= 1'b0;
            fill_done <= 1'b0;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (st_go) begin
                        state <= WRITE;
                        mem_a <= st_head.addr;
                        mem_dout <= st_head.data[7:0];
                        wdata_q <= st_head.data[31:8];
                        last_q <= CNT_BITS'(st_head.len);
                        mem_wr_q <= 1'b1;
                    end else if (ld_go) begin
                        state <= READ;
                        fill_q <= 1'b0;
                        mem_a <= ld_head.addr;
                        last_q <= CNT_BITS'(ld_head.len);
                        len_q <= ld_head.len;
                        sext_q <= ld_head.sext;
                        ld_tag <= ld_head.tag;
                    end else if (fill_go) begin
                        state <= READ;
                        fill_q <= 1'b1;
                        mem_a <= fill_addr;
                        last_q <= CNT_BITS'(`LINE_BYTES - 1);
                    end
                end
                READ: begin
                    if (cnt < last_q) begin
                        mem_a <= mem_a + 32'd1;
                    end
                    if (cnt != '0) begin
                        asm_q[rx_idx*8 +: 8] <= mem_din;
                    end
                    if (cnt == last_q + 1'b1) begin
                        state <= IDLE;
                        ld_done <= !fill_q;
                        fill_done <= fill_q;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WRITE: begin
                    if (cnt == last_q) begin
                        state <= IDLE;
                        mem_wr_q <= 1'b0;
                        st_done <= 1'b1;
                    end else begin
                        mem_a <= mem_a + 32'd1;
                        mem_dout <= wdata_q[7:0];
                        wdata_q <= wdata_q >> 8;
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // pause masks writes and freezes the bus
    a_pause_bus: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |-> !mem_wr ##1 ($stable(mem_a) && $stable(mem_dout)));
    a_cnt_range: assert property (@(posedge clk_in) disable iff (rst_in)
        cnt <= CNT_BITS'(`LINE_BYTES));

endmodule
